// File: hdl/lsu_pkg.sv
package lsu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Vector types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [31:0] word_t;       // Data word or byte address
    typedef logic [7:0]  inst_type_t;  // Instruction class from decode
    typedef logic [7:0]  lsu_op_t;     // Memory opcode from decode
    typedef logic [3:0]  strb_t;       // One bit per byte lane
    typedef logic [2:0]  axsize_t;     // AXI transfer size, log2 of bytes
    typedef logic [1:0]  resp_t;       // AXI response code

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam inst_type_t INST_LOAD  = 8'h01;
    localparam inst_type_t INST_STORE = 8'h02;

    localparam lsu_op_t LSU_OP_SB  = 8'h01;
    localparam lsu_op_t LSU_OP_SH  = 8'h02;
    localparam lsu_op_t LSU_OP_SW  = 8'h03;
    localparam lsu_op_t LSU_OP_LB  = 8'h04;
    localparam lsu_op_t LSU_OP_LBU = 8'h05;
    localparam lsu_op_t LSU_OP_LH  = 8'h06;
    localparam lsu_op_t LSU_OP_LHU = 8'h07;
    localparam lsu_op_t LSU_OP_LW  = 8'h08;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus encodings and memory size
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam axsize_t SIZE_BYTE = 3'd0;
    localparam axsize_t SIZE_HALF = 3'd1;
    localparam axsize_t SIZE_WORD = 3'd2;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;

    localparam logic [1:0] BURST_INCR = 2'b01;

    localparam int RAM_WORDS   = 1024;  // Byte addresses from 4*RAM_WORDS up fail
    localparam int RAM_INDEX_W = 10;    // log2 of RAM_WORDS

endpackage

// File: hdl/lsu_store_align.sv
`timescale 1ns/1ps

module lsu_store_align (
    input  lsu_pkg::lsu_op_t lsu_op_i,
    input  lsu_pkg::word_t   address_i,
    input  lsu_pkg::word_t   store_data_i,
    output logic [1:0]       byte_lane_o,
    output logic             misaligned_o,
    output lsu_pkg::word_t   wdata_o,
    output lsu_pkg::strb_t   wstrb_o,
    output lsu_pkg::axsize_t size_o
);
    import lsu_pkg::*;

    logic [4:0] lane_shift;

    assign byte_lane_o = address_i[1:0];
    assign lane_shift  = {address_i[1:0], 3'b000};  // Bit offset of the addressed lane

    // Halfwords need an even lane, words need lane zero
    always_comb begin
        case (lsu_op_i)
            LSU_OP_SH, LSU_OP_LH, LSU_OP_LHU: misaligned_o = address_i[0];
            LSU_OP_SW, LSU_OP_LW:             misaligned_o = (address_i[1:0] != 2'b00);
            default:                          misaligned_o = 1'b0;
        endcase
    end

    always_comb begin
        case (lsu_op_i)
            LSU_OP_SB, LSU_OP_LB, LSU_OP_LBU: size_o = SIZE_BYTE;
            LSU_OP_SH, LSU_OP_LH, LSU_OP_LHU: size_o = SIZE_HALF;
            LSU_OP_SW, LSU_OP_LW:             size_o = SIZE_WORD;
            default:                          size_o = SIZE_BYTE;
        endcase
    end

    // Store data moves up to its lane and the strobe follows it
    always_comb begin
        case (lsu_op_i)
            LSU_OP_SB: begin
                wdata_o = {24'h0, store_data_i[7:0]} << lane_shift;
                wstrb_o = 4'b0001 << address_i[1:0];
            end
            LSU_OP_SH: begin
                wdata_o = {16'h0, store_data_i[15:0]} << lane_shift;
                wstrb_o = 4'b0011 << address_i[1:0];
            end
            LSU_OP_SW: begin
                wdata_o = store_data_i;
                wstrb_o = 4'b1111;
            end
            default: begin
                wdata_o = '0;  // Loads write nothing
                wstrb_o = '0;
            end
        endcase
    end

endmodule

// File: hdl/lsu.sv
`timescale 1ns/1ps

module lsu (
    input  logic                 clock,
    input  logic                 reset,
    // Core side
    input  lsu_pkg::inst_type_t  inst_type_i,
    input  lsu_pkg::lsu_op_t     lsu_op_i,
    input  lsu_pkg::word_t       imm_i,
    input  lsu_pkg::word_t       rdata1_i,
    input  lsu_pkg::word_t       rdata2_i,
    input  logic                 access_begin_i,
    output logic                 access_done_o,
    output logic                 access_error_o,
    output lsu_pkg::word_t       mem_result_o,
    // Write address channel
    output logic                 awvalid_o,
    output lsu_pkg::word_t       awaddr_o,
    output lsu_pkg::axsize_t     awsize_o,
    output logic [1:0]           awburst_o,
    output logic [3:0]           awid_o,
    output logic [7:0]           awlen_o,
    input  logic                 awready_i,
    // Write data channel
    output logic                 wvalid_o,
    output lsu_pkg::word_t       wdata_o,
    output lsu_pkg::strb_t       wstrb_o,
    output logic                 wlast_o,
    input  logic                 wready_i,
    // Write response channel
    output logic                 bready_o,
    input  logic                 bvalid_i,
    input  lsu_pkg::resp_t       bresp_i,
    // Read address channel
    output logic                 arvalid_o,
    output lsu_pkg::word_t       araddr_o,
    output lsu_pkg::axsize_t     arsize_o,
    output logic [1:0]           arburst_o,
    output logic [3:0]           arid_o,
    output logic [7:0]           arlen_o,
    input  logic                 arready_i,
    // Read data channel
    output logic                 rready_o,
    input  logic                 rvalid_i,
    input  lsu_pkg::resp_t       rresp_i,
    input  lsu_pkg::word_t       rdata_i,
    input  logic                 rlast_i
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        IDLE,
        MISALIGN_DONE,
        WAIT_AW,
        WAIT_B,
        WAIT_AR,
        WAIT_R
    } state_t;

    state_t     state;
    state_t     state_next;
    word_t      address;
    word_t      lane_data;
    word_t      load_value;
    logic [1:0] byte_lane;
    logic       misaligned;
    axsize_t    xfer_size;
    logic       read_err;
    logic       write_err;

    assign address = rdata1_i + imm_i;  // Effective address

    lsu_store_align u_align (
        .lsu_op_i     (lsu_op_i),
        .address_i    (address),
        .store_data_i (rdata2_i),
        .byte_lane_o  (byte_lane),
        .misaligned_o (misaligned),
        .wdata_o      (wdata_o),
        .wstrb_o      (wstrb_o),
        .size_o       (xfer_size)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Access FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (access_begin_i && (inst_type_i == INST_LOAD || inst_type_i == INST_STORE)) begin
                    if (misaligned) begin
                        state_next = MISALIGN_DONE;  // Finish without touching the bus
                    end else if (inst_type_i == INST_LOAD) begin
                        state_next = WAIT_AR;
                    end else begin
                        state_next = WAIT_AW;
                    end
                end
            end
            MISALIGN_DONE: state_next = IDLE;
            WAIT_AW:       if (awready_i && wready_i) state_next = WAIT_B;
            WAIT_B:        if (bvalid_i) state_next = IDLE;
            WAIT_AR:       if (arready_i) state_next = WAIT_R;
            WAIT_R:        if (rvalid_i) state_next = IDLE;
            default:       state_next = IDLE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus channels
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign awvalid_o = (state == WAIT_AW);
    assign awaddr_o  = address;
    assign awsize_o  = xfer_size;
    assign awburst_o = BURST_INCR;
    assign awid_o    = 4'd0;
    assign awlen_o   = 8'd0;   // Single beat

    assign wvalid_o  = (state == WAIT_AW);  // Raised together with awvalid
    assign wlast_o   = 1'b1;
    assign bready_o  = (state == WAIT_B);

    assign arvalid_o = (state == WAIT_AR);
    assign araddr_o  = address;
    assign arsize_o  = xfer_size;
    assign arburst_o = BURST_INCR;
    assign arid_o    = 4'd0;
    assign arlen_o   = 8'd0;
    assign rready_o  = (state == WAIT_R);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Completion and load result
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign write_err = (bresp_i != RESP_OKAY);
    assign read_err  = (rresp_i != RESP_OKAY) || !rlast_i;  // A single beat must be the last

    assign access_done_o  = (state == MISALIGN_DONE) ||
                            (state == WAIT_B && bvalid_i) ||
                            (state == WAIT_R && rvalid_i);
    assign access_error_o = (state == MISALIGN_DONE) ||
                            (state == WAIT_B && bvalid_i && write_err) ||
                            (state == WAIT_R && rvalid_i && read_err);

    // Addressed lane comes down to bit zero before extension
    always_comb begin
        lane_data = rdata_i >> {byte_lane, 3'b000};
        case (lsu_op_i)
            LSU_OP_LB:  load_value = {{24{lane_data[7]}}, lane_data[7:0]};
            LSU_OP_LBU: load_value = {24'h0, lane_data[7:0]};
            LSU_OP_LH:  load_value = {{16{lane_data[15]}}, lane_data[15:0]};
            LSU_OP_LHU: load_value = {16'h0, lane_data[15:0]};
            default:    load_value = rdata_i;  // LW
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            mem_result_o <= '0;
        end else if (state == WAIT_R && rvalid_i && !read_err) begin
            mem_result_o <= load_value;  // Failed reads keep the old result
        end
    end

endmodule

// File: hdl/axi_data_ram.sv
`timescale 1ns/1ps

module axi_data_ram (
    input  logic             clock,
    input  logic             reset,
    // Write address channel
    input  logic             awvalid_i,
    input  lsu_pkg::word_t   awaddr_i,
    input  lsu_pkg::axsize_t awsize_i,
    input  logic [1:0]       awburst_i,
    input  logic [3:0]       awid_i,
    input  logic [7:0]       awlen_i,
    output logic             awready_o,
    // Write data channel
    input  logic             wvalid_i,
    input  lsu_pkg::word_t   wdata_i,
    input  lsu_pkg::strb_t   wstrb_i,
    input  logic             wlast_i,
    output logic             wready_o,
    // Write response channel
    input  logic             bready_i,
    output logic             bvalid_o,
    output lsu_pkg::resp_t   bresp_o,
    // Read address channel
    input  logic             arvalid_i,
    input  lsu_pkg::word_t   araddr_i,
    input  lsu_pkg::axsize_t arsize_i,
    input  logic [1:0]       arburst_i,
    input  logic [3:0]       arid_i,
    input  logic [7:0]       arlen_i,
    output logic             arready_o,
    // Read data channel
    input  logic             rready_i,
    output logic             rvalid_o,
    output lsu_pkg::resp_t   rresp_o,
    output lsu_pkg::word_t   rdata_o,
    output logic             rlast_o
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        RAM_IDLE,
        W_ACCEPT,
        W_EXEC,
        B_RESP,
        R_ACCEPT,
        R_EXEC,
        R_RESP
    } ram_state_t;

    ram_state_t             state;
    ram_state_t             state_next;
    word_t                  mem [RAM_WORDS];
    word_t                  addr_q;
    word_t                  wdata_q;
    word_t                  rdata_q;
    strb_t                  wstrb_q;
    resp_t                  resp_q;
    logic                   bad_q;
    logic                   wr_bad;
    logic                   rd_bad;
    logic                   in_range;
    logic [RAM_INDEX_W-1:0] index;

    // Anything but a single zero-ID incrementing beat of at most a word is refused
    assign wr_bad = (awlen_i != 8'd0) || (awburst_i != BURST_INCR) ||
                    (awsize_i > SIZE_WORD) || (awid_i != 4'd0) || !wlast_i;
    assign rd_bad = (arlen_i != 8'd0) || (arburst_i != BURST_INCR) ||
                    (arsize_i > SIZE_WORD) || (arid_i != 4'd0);

    assign in_range = (addr_q[31:RAM_INDEX_W+2] == '0);
    assign index    = addr_q[RAM_INDEX_W+1:2];

    assign awready_o = (state == W_ACCEPT);
    assign wready_o  = (state == W_ACCEPT);
    assign bvalid_o  = (state == B_RESP);
    assign bresp_o   = resp_q;
    assign arready_o = (state == R_ACCEPT);
    assign rvalid_o  = (state == R_RESP);
    assign rresp_o   = resp_q;
    assign rdata_o   = rdata_q;
    assign rlast_o   = (state == R_RESP);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= RAM_IDLE;
        end else begin
            state <= state_next;
        end
    end

    // Writes wait for both valids, reads go only when no write is pending
    always_comb begin
        state_next = state;
        case (state)
            RAM_IDLE: begin
                if (awvalid_i && wvalid_i) begin
                    state_next = W_ACCEPT;
                end else if (arvalid_i) begin
                    state_next = R_ACCEPT;
                end
            end
            W_ACCEPT: state_next = (awvalid_i && wvalid_i) ? W_EXEC : RAM_IDLE;
            W_EXEC:   state_next = B_RESP;
            B_RESP:   if (bready_i) state_next = RAM_IDLE;
            R_ACCEPT: state_next = arvalid_i ? R_EXEC : RAM_IDLE;
            R_EXEC:   state_next = R_RESP;
            R_RESP:   if (rready_i) state_next = RAM_IDLE;
            default:  state_next = RAM_IDLE;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request capture and storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clock) begin
        if (state == W_ACCEPT && awvalid_i && wvalid_i) begin
            addr_q  <= awaddr_i;
            wdata_q <= wdata_i;
            wstrb_q <= wstrb_i;
            bad_q   <= wr_bad;
        end
        if (state == R_ACCEPT && arvalid_i) begin
            addr_q <= araddr_i;
            bad_q  <= rd_bad;
        end
        if (state == W_EXEC || state == R_EXEC) begin
            resp_q <= (bad_q || !in_range) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    always_ff @(posedge clock) begin
        if (state == W_EXEC && !bad_q && in_range) begin
            for (int i = 0; i < 4; i++) begin
                if (wstrb_q[i]) begin
                    mem[index][8*i +: 8] <= wdata_q[8*i +: 8];  // Only strobed lanes change
                end
            end
        end
        if (state == R_EXEC) begin
            rdata_q <= mem[index];
        end
    end

endmodule

// File: hdl/lsu_subsys.sv
`timescale 1ns/1ps

module lsu_subsys (
    input  logic                clock,
    input  logic                reset,
    input  lsu_pkg::inst_type_t inst_type_i,
    input  lsu_pkg::lsu_op_t    lsu_op_i,
    input  lsu_pkg::word_t      imm_i,
    input  lsu_pkg::word_t      rdata1_i,
    input  lsu_pkg::word_t      rdata2_i,
    input  logic                access_begin_i,
    output logic                access_done_o,
    output logic                access_error_o,
    output lsu_pkg::word_t      mem_result_o
);
    import lsu_pkg::*;

    // Bus between the unit and the RAM, one group per channel
    logic       aw_valid, aw_ready, w_valid, w_ready, w_last;
    logic       b_valid, b_ready, ar_valid, ar_ready, r_valid, r_ready, r_last;
    word_t      aw_addr, ar_addr, w_data, r_data;
    axsize_t    aw_size, ar_size;
    logic [1:0] aw_burst, ar_burst;
    logic [3:0] aw_id, ar_id;
    logic [7:0] aw_len, ar_len;
    strb_t      w_strb;
    resp_t      b_resp, r_resp;

    lsu u_lsu (
        .clock(clock), .reset(reset),
        .inst_type_i(inst_type_i), .lsu_op_i(lsu_op_i), .imm_i(imm_i),
        .rdata1_i(rdata1_i), .rdata2_i(rdata2_i), .access_begin_i(access_begin_i),
        .access_done_o(access_done_o), .access_error_o(access_error_o),
        .mem_result_o(mem_result_o),
        .awvalid_o(aw_valid), .awaddr_o(aw_addr), .awsize_o(aw_size),
        .awburst_o(aw_burst), .awid_o(aw_id), .awlen_o(aw_len), .awready_i(aw_ready),
        .wvalid_o(w_valid), .wdata_o(w_data), .wstrb_o(w_strb), .wlast_o(w_last),
        .wready_i(w_ready),
        .bready_o(b_ready), .bvalid_i(b_valid), .bresp_i(b_resp),
        .arvalid_o(ar_valid), .araddr_o(ar_addr), .arsize_o(ar_size),
        .arburst_o(ar_burst), .arid_o(ar_id), .arlen_o(ar_len), .arready_i(ar_ready),
        .rready_o(r_ready), .rvalid_i(r_valid), .rresp_i(r_resp), .rdata_i(r_data),
        .rlast_i(r_last)
    );

    axi_data_ram u_ram (
        .clock(clock), .reset(reset),
        .awvalid_i(aw_valid), .awaddr_i(aw_addr), .awsize_i(aw_size),
        .awburst_i(aw_burst), .awid_i(aw_id), .awlen_i(aw_len), .awready_o(aw_ready),
        .wvalid_i(w_valid), .wdata_i(w_data), .wstrb_i(w_strb), .wlast_i(w_last),
        .wready_o(w_ready),
        .bready_i(b_ready), .bvalid_o(b_valid), .bresp_o(b_resp),
        .arvalid_i(ar_valid), .araddr_i(ar_addr), .arsize_i(ar_size),
        .arburst_i(ar_burst), .arid_i(ar_id), .arlen_i(ar_len), .arready_o(ar_ready),
        .rready_i(r_ready), .rvalid_o(r_valid), .rresp_o(r_resp), .rdata_o(r_data),
        .rlast_o(r_last)
    );

endmodule

// File: verification/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker (
    input  logic           clock,
    input  logic           reset,
    input  logic           access_begin_i,
    input  logic           access_done_i,
    input  logic           access_error_i,
    input  lsu_pkg::word_t mem_result_i,
    output int             error_count_o
);
    import lsu_pkg::*;

    typedef struct packed {
        logic       error;
        word_t      result;
        logic [7:0] latency;
    } exp_rec_t;

    exp_rec_t exp_q[$];
    exp_rec_t cur;
    word_t    exp_result;      // Value mem_result_o must hold right now
    word_t    next_result;
    logic     result_pending;
    int       cycle_count;
    int       begin_cycle;

    initial error_count_o = 0;

    task push_expect(input logic error, input word_t result, input int latency);
        exp_q.push_back({error, result, latency[7:0]});
    endtask

    function int pending_count();
        return exp_q.size();
    endfunction

    task print_summary(input int timeouts);
        $display("checker: %0d mismatches, %0d timeouts, %0d accesses unanswered",
                 error_count_o, timeouts, exp_q.size());
    endtask

    // Outputs are sampled mid-cycle, well away from the rising edge
    always @(negedge clock) begin
        if (reset) begin
            cycle_count    = 0;
            exp_result     = '0;
            result_pending = 1'b0;
        end else begin
            cycle_count++;
            if (result_pending) begin
                exp_result     = next_result;  // The result register moved at the last edge
                result_pending = 1'b0;
            end
            if (mem_result_i !== exp_result) begin
                $display("mismatch at %0t: mem_result_o is %h, expected %h",
                         $time, mem_result_i, exp_result);
                error_count_o++;
            end
            if (access_begin_i) begin
                begin_cycle = cycle_count;
            end
            if (access_done_i) begin
                if (exp_q.size() == 0) begin
                    $display("access_done_o rose at %0t with no access pending", $time);
                    error_count_o++;
                end else begin
                    cur = exp_q.pop_front();
                    if (access_error_i !== cur.error) begin
                        $display("mismatch at %0t: access_error_o is %b, expected %b",
                                 $time, access_error_i, cur.error);
                        error_count_o++;
                    end
                    if (cycle_count - begin_cycle != cur.latency) begin
                        $display("mismatch at %0t: done after %0d cycles, expected %0d",
                                 $time, cycle_count - begin_cycle, cur.latency);
                        error_count_o++;
                    end
                    next_result    = cur.result;
                    result_pending = 1'b1;
                end
            end
        end
    end

endmodule

// File: verification/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu;
    import lsu_pkg::*;

    localparam int          NUM_TRANS      = 600;
    localparam int          TIMEOUT_CYCLES = 50;
    localparam int          RAM_BYTES      = 4 * RAM_WORDS;
    localparam logic [31:0] SEED           = 32'h1fbe_1381;

    logic       clock;
    logic       reset;
    inst_type_t inst_type;
    lsu_op_t    lsu_op;
    word_t      imm;
    word_t      rdata1;
    word_t      rdata2;
    logic       access_begin;
    logic       access_done;
    logic       access_error;
    word_t      mem_result;
    int         error_count;
    logic [7:0] model_mem [RAM_BYTES];  // Byte image of the RAM, unknown until written
    word_t      last_result;
    logic [31:0] rng_state;
    int         timeout_count;
    logic       hung;

    lsu_subsys dut0 (
        .clock(clock), .reset(reset),
        .inst_type_i(inst_type), .lsu_op_i(lsu_op), .imm_i(imm),
        .rdata1_i(rdata1), .rdata2_i(rdata2), .access_begin_i(access_begin),
        .access_done_o(access_done), .access_error_o(access_error),
        .mem_result_o(mem_result)
    );

    lsu_checker chk0 (
        .clock(clock), .reset(reset),
        .access_begin_i(access_begin), .access_done_i(access_done),
        .access_error_i(access_error), .mem_result_i(mem_result),
        .error_count_o(error_count)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Little-endian byte model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic word_t load_model(input lsu_op_t op, input word_t addr);
        logic [15:0] half;
        half = {model_mem[addr + 1], model_mem[addr]};
        case (op)
            LSU_OP_LB:  return {{24{model_mem[addr][7]}}, model_mem[addr]};
            LSU_OP_LBU: return {24'h0, model_mem[addr]};
            LSU_OP_LH:  return {{16{half[15]}}, half};
            LSU_OP_LHU: return {16'h0, half};
            default:    return {model_mem[addr + 3], model_mem[addr + 2], half};
        endcase
    endfunction

    task store_model(input lsu_op_t op, input word_t addr, input word_t data);
        model_mem[addr] = data[7:0];
        if (op != LSU_OP_SB) begin
            model_mem[addr + 1] = data[15:8];
        end
        if (op == LSU_OP_SW) begin
            model_mem[addr + 2] = data[23:16];
            model_mem[addr + 3] = data[31:24];
        end
    endtask

    // One access from begin to done, with the base register picked at random
    task run_access(input inst_type_t itype, input lsu_op_t op, input word_t addr,
                    input word_t data);
        logic misaligned;
        logic err;
        logic seen;
        int   waited;
        misaligned = ((op == LSU_OP_SH || op == LSU_OP_LH || op == LSU_OP_LHU) && addr[0]) ||
                     ((op == LSU_OP_SW || op == LSU_OP_LW) && addr[1:0] != 2'b00);
        err = misaligned || (addr >= RAM_BYTES);
        if (!err && itype == INST_LOAD) begin
            last_result = load_model(op, addr);
        end else if (!err) begin
            store_model(op, addr, data);
        end
        chk0.push_expect(err, last_result, misaligned ? 1 : 4);
        rng_state = xorshift32(rng_state);
        @(posedge clock);
        #2;
        inst_type    = itype;
        lsu_op       = op;
        rdata1       = rng_state;
        imm          = addr - rng_state;  // Base plus immediate lands on addr
        rdata2       = data;
        access_begin = 1'b1;
        @(posedge clock);
        #2;
        access_begin = 1'b0;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < TIMEOUT_CYCLES) begin
            @(negedge clock);
            seen = access_done;
            waited++;
        end
        if (!seen) begin
            $display("timeout: no access_done_o within %0d cycles at %0t", TIMEOUT_CYCLES, $time);
            timeout_count++;
            hung = 1'b1;
        end
    endtask

    task random_access;
        lsu_op_t    op;
        word_t      addr;
        logic [3:0] mode;
        logic [2:0] pick;
        rng_state = xorshift32(rng_state);
        pick = rng_state[2:0];
        mode = rng_state[7:4];
        addr = {24'h0, rng_state[15:8]};  // 256-byte window
        case (pick)
            3'd0: op = LSU_OP_SB;
            3'd1: op = LSU_OP_SH;
            3'd2: op = LSU_OP_SW;
            3'd3: op = LSU_OP_LB;
            3'd4: op = LSU_OP_LBU;
            3'd5: op = LSU_OP_LH;
            3'd6: op = LSU_OP_LHU;
            default: op = LSU_OP_LW;
        endcase
        if (op == LSU_OP_SH || op == LSU_OP_LH || op == LSU_OP_LHU) begin
            addr = (mode >= 4'd14) ? (addr | 32'd1) : (addr & ~32'd1);
        end else if (op == LSU_OP_SW || op == LSU_OP_LW) begin
            addr = (addr & ~32'd3) | ((mode >= 4'd14) ? (1 + rng_state[17:16] % 3) : 0);
        end
        if (mode == 4'd13) begin
            addr = addr | (({12'h0, rng_state[31:12]} | 32'd1) << 12);  // Beyond the RAM
        end
        rng_state = xorshift32(rng_state);
        run_access((pick < 3'd3) ? INST_STORE : INST_LOAD, op, addr, rng_state);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        reset         = 1'b1;
        inst_type     = '0;
        lsu_op        = '0;
        imm           = '0;
        rdata1        = '0;
        rdata2        = '0;
        access_begin  = 1'b0;
        rng_state     = SEED;
        last_result   = '0;
        timeout_count = 0;
        hung          = 1'b0;
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;
        repeat (4) @(posedge clock);  // Idle after reset, no done and a zero result
        #2;
        inst_type    = 8'h00;         // Neither load nor store, so no response
        lsu_op       = LSU_OP_LW;
        access_begin = 1'b1;
        @(posedge clock);
        #2;
        access_begin = 1'b0;
        repeat (6) @(posedge clock);
        for (int a = 0; a < 256 && !hung; a += 4) begin
            run_access(INST_STORE, LSU_OP_SW, a, a * 32'h9e37_79b9 ^ 32'hc3a5_0f1e);
        end
        for (int n = 0; n < NUM_TRANS && !hung; n++) begin
            random_access();
        end
        repeat (3) @(posedge clock);
        chk0.print_summary(timeout_count);
        if (error_count == 0 && timeout_count == 0 && chk0.pending_count() == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/lsu_pkg.sv
hdl/lsu_store_align.sv
hdl/lsu.sv
hdl/axi_data_ram.sv
hdl/lsu_subsys.sv
verification/lsu_checker.sv
verification/tb_lsu.sv
